// ==== verilog/xray_defines.svh ====
`ifndef XRAY_DEFINES_SVH
`define XRAY_DEFINES_SVH

// identity byte for get_cookie
`define XRAY_COOKIE 8'haf

// version reply packs as {major[2:0], minor[4:0]}
`define XRAY_VERSION_MAJOR 3'd0
`define XRAY_VERSION_MINOR 5'd3

// breakpoint slots, default count
`define XRAY_NUM_SLOTS 8

// widths
`define XRAY_ADDR_W     16 // cpu address
`define XRAY_BYTE_W     8  // spi byte
`define XRAY_SLOT_IDX_W 3  // enough for 8 slots

// flops per spi input synchronizer
`define XRAY_SYNC_STAGES 2

`endif

// ==== verilog/xray_pkg.sv ====
`include "xray_defines.svh"

package xray_pkg;

  // one spi byte on the command link
  typedef logic [`XRAY_BYTE_W-1:0] spi_byte_t;

  // opcode numbers of the debugger protocol
  typedef enum logic [`XRAY_BYTE_W-1:0] {
    op_get_cookie          = 8'd0,
    op_set_breakpoint      = 8'd6,  // slot, addr lo, addr hi
    op_clear_breakpoint    = 8'd7,  // slot
    op_enable_breakpoints  = 8'd11,
    op_disable_breakpoints = 8'd12,
    op_xray_resume         = 8'd13,
    op_get_version         = 8'd15
  } cmd_opcode_t;

  // debugger run state
  typedef enum logic [1:0] {
    st_run    = 2'b00,
    st_stop   = 2'b01,
    st_resume = 2'b11 // waiting for fetch at stop addr
  } xray_state_t;

  typedef logic [`XRAY_ADDR_W-1:0]     cpu_addr_t;
  typedef logic [`XRAY_SLOT_IDX_W-1:0] slot_idx_t;

endpackage

// ==== verilog/spi_target.sv ====
`include "xray_defines.svh"

module spi_target
  import xray_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      sck,
  input  logic      mosi,
  input  logic      cs_n,
  output logic      miso,
  output spi_byte_t rx_byte,
  output logic      rx_valid,
  output logic      msg_start,
  input  spi_byte_t tx_byte,
  input  logic      tx_load
);

  localparam int sync_n = `XRAY_SYNC_STAGES;

  logic [sync_n-1:0] sck_sync;
  logic [sync_n-1:0] mosi_sync;
  logic [sync_n-1:0] cs_sync;
  logic              sck_prev;
  logic              cs_prev;
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_active;
  logic              mosi_s;
  logic [2:0]        bit_cnt;      // bits seen in current byte
  spi_byte_t         rx_sr;
  spi_byte_t         tx_sr;        // miso shifter
  spi_byte_t         tx_hold;      // reply waiting for byte boundary
  logic              tx_pending;
  logic              reply_active; // current byte carries a reply

  // input synchronizers, idle levels after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      mosi_sync <= '0;
      cs_sync   <= '1;
      sck_prev  <= 1'b0;
      cs_prev   <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[sync_n-2:0], sck};
      mosi_sync <= {mosi_sync[sync_n-2:0], mosi};
      cs_sync   <= {cs_sync[sync_n-2:0], cs_n};
      sck_prev  <= sck_sync[sync_n-1];
      cs_prev   <= cs_sync[sync_n-1];
    end
  end

  assign mosi_s    = mosi_sync[sync_n-1];
  assign cs_active = ~cs_sync[sync_n-1];
  assign sck_rise  = sck_sync[sync_n-1] & ~sck_prev;
  assign sck_fall  = ~sck_sync[sync_n-1] & sck_prev;
  assign msg_start = cs_prev & ~cs_sync[sync_n-1]; // cs_n falling

  // receive side, mode 0 samples on rising sck
  always_ff @(posedge clk) begin
    if (!rst_n || !cs_active) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_valid <= (bit_cnt == 3'd7) && !reply_active; // reply byte mosi is dropped
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise) begin
      rx_sr <= {rx_sr[6:0], mosi_s}; // msb first
    end
  end

  assign rx_byte = rx_sr;

  // reply bookkeeping
  always_ff @(posedge clk) begin
    if (!rst_n || !cs_active) begin
      tx_pending   <= 1'b0;
      reply_active <= 1'b0;
    end else begin
      if (sck_fall && bit_cnt == 3'd0) begin
        reply_active <= tx_pending;
        tx_pending   <= 1'b0;
      end
      if (tx_load) tx_pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) tx_hold <= tx_byte;
  end

  // shift out on falling sck, reload at the byte boundary
  always_ff @(posedge clk) begin
    if (!cs_active) begin
      tx_sr <= '0;
    end else if (sck_fall) begin
      if (bit_cnt == 3'd0) tx_sr <= tx_pending ? tx_hold : '0; // zeros when nothing queued
      else                 tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = cs_active & tx_sr[7]; // low outside a transfer

endmodule

// ==== verilog/cmd_decoder.sv ====
`include "xray_defines.svh"

module cmd_decoder
  import xray_pkg::*;
#(
  parameter int num_slots = `XRAY_NUM_SLOTS
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  spi_byte_t            rx_byte,
  input  logic                 rx_valid,
  input  logic                 msg_start,
  output spi_byte_t            tx_byte,
  output logic                 tx_load,
  output logic [num_slots-1:0] slot_wr_en,
  output cpu_addr_t            slot_wr_addr,
  output logic                 slot_wr_active,
  output logic                 bp_enable,
  output logic                 resume_req
);

  localparam int idx_w = (num_slots > 1) ? $clog2(num_slots) : 1;

  typedef enum logic {
    dec_idle,
    dec_read_params
  } dec_state_t;

  dec_state_t  state;
  cmd_opcode_t cmd;        // opcode of message in progress
  logic [1:0]  param_left; // bytes still expected
  logic        param_idx;
  spi_byte_t   params [0:1];
  cmd_opcode_t op;
  logic        last_byte;
  logic        fire;       // action strobe
  spi_byte_t   slot_byte;

  // parameter bytes per opcode
  function automatic logic [1:0] param_count(cmd_opcode_t opc);
    case (opc)
      op_set_breakpoint:   return 2'd3;
      op_clear_breakpoint: return 2'd1;
      default:             return 2'd0;
    endcase
  endfunction

  always_comb begin
    op        = (state == dec_idle) ? cmd_opcode_t'(rx_byte) : cmd;
    last_byte = (state == dec_idle) ? (param_count(op) == 2'd0) : (param_left == 2'd1);
    fire      = rx_valid && last_byte;
    // clear sends its slot as the only param, so it is the live byte
    slot_byte = (op == op_set_breakpoint) ? params[0] : rx_byte;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || msg_start) begin // new message resyncs the parser
      state      <= dec_idle;
      param_left <= '0;
      param_idx  <= 1'b0;
    end else if (rx_valid) begin
      case (state)
        dec_idle: begin
          param_left <= param_count(op);
          param_idx  <= 1'b0;
          if (!last_byte) state <= dec_read_params;
        end
        dec_read_params: begin
          if (last_byte) begin
            state <= dec_idle;
          end else begin
            param_left <= param_left - 2'd1;
            param_idx  <= param_idx + 1'b1;
          end
        end
        default: state <= dec_idle;
      endcase
    end
  end

  // opcode and params, last byte is used live
  always_ff @(posedge clk) begin
    if (rx_valid && state == dec_idle) cmd <= op;
    if (rx_valid && state == dec_read_params && !last_byte) params[param_idx] <= rx_byte;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bp_enable <= 1'b0;
    end else if (fire && op == op_enable_breakpoints) begin
      bp_enable <= 1'b1;
    end else if (fire && op == op_disable_breakpoints) begin
      bp_enable <= 1'b0;
    end
  end

  // slot write, index truncated to slot count
  always_comb begin
    slot_wr_en = '0;
    if (fire && (op == op_set_breakpoint || op == op_clear_breakpoint)) begin
      slot_wr_en[slot_byte[idx_w-1:0]] = 1'b1;
    end
  end

  assign slot_wr_addr   = {rx_byte, params[1]}; // hi byte arrives last
  assign slot_wr_active = (op == op_set_breakpoint);
  assign resume_req     = fire && (op == op_xray_resume);

  // queries
  assign tx_load = fire && (op == op_get_cookie || op == op_get_version);
  assign tx_byte = (op == op_get_version) ? {`XRAY_VERSION_MAJOR, `XRAY_VERSION_MINOR}
                                          : `XRAY_COOKIE;

endmodule

// ==== verilog/breakpoint_slot.sv ====
module breakpoint_slot
  import xray_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_en,
  input  cpu_addr_t wr_addr,
  input  logic      wr_active,
  input  cpu_addr_t bus_addr,
  output logic      hit
);

  cpu_addr_t bp_addr; // breakpoint address
  logic      active;

  // active flag, cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
    end else if (wr_en) begin
      active <= wr_active; // set arms, clear disarms
    end
  end

  // address only matters while active
  always_ff @(posedge clk) begin
    if (wr_en) begin
      bp_addr <= wr_addr;
    end
  end

  // compare against live bus address
  assign hit = active && (bp_addr == bus_addr);

endmodule

// ==== verilog/stub_control.sv ====
`include "xray_defines.svh"

module stub_control
  import xray_pkg::*;
#(
  parameter int num_slots = `XRAY_NUM_SLOTS
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [num_slots-1:0] slot_hit,
  input  cpu_addr_t            bus_addr,
  input  logic                 bus_fetch,
  input  logic                 bp_enable,
  input  logic                 resume_req,
  output logic                 halted,
  output slot_idx_t            hit_index
);

  xray_state_t state;
  cpu_addr_t   stop_addr; // address where cpu was stopped
  slot_idx_t   first_hit;
  logic        any_hit;

  // lowest slot wins
  always_comb begin
    first_hit = '0;
    for (int i = num_slots - 1; i >= 0; i--) begin
      if (slot_hit[i]) first_hit = slot_idx_t'(i);
    end
  end

  assign any_hit = |slot_hit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_run;
      hit_index <= '0;
    end else begin
      case (state)
        st_run: begin
          if (bus_fetch && bp_enable && any_hit) begin
            state     <= st_stop;
            hit_index <= first_hit;
          end
        end
        st_stop: begin
          if (resume_req) state <= st_resume; // host lets cpu go
        end
        st_resume: begin
          // back to run once the stopped instruction is fetched again
          if (bus_fetch && bus_addr == stop_addr) state <= st_run;
        end
        default: state <= st_run;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_run && bus_fetch && bp_enable && any_hit) begin
      stop_addr <= bus_addr;
    end
  end

  assign halted = (state != st_run); // stop and resume both hold the cpu

endmodule

// ==== verilog/xray_top.sv ====
`include "xray_defines.svh"

module xray_top #(
  parameter int num_slots = `XRAY_NUM_SLOTS
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        sck,
  input  logic                        mosi,
  input  logic                        cs_n,
  output logic                        miso,
  input  logic [`XRAY_ADDR_W-1:0]     bus_addr,
  input  logic                        bus_fetch,
  output logic                        halted,
  output logic [`XRAY_SLOT_IDX_W-1:0] hit_index
);

  logic [`XRAY_BYTE_W-1:0] rx_byte;
  logic                    rx_valid;
  logic                    msg_start;
  logic [`XRAY_BYTE_W-1:0] tx_byte;
  logic                    tx_load;
  logic [num_slots-1:0]    slot_wr_en;     // one per slot
  logic [`XRAY_ADDR_W-1:0] slot_wr_addr;   // shared write data
  logic                    slot_wr_active;
  logic                    bp_enable;
  logic                    resume_req;
  logic [num_slots-1:0]    slot_hit;

  spi_target spi_target_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .miso      (miso),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .msg_start (msg_start),
    .tx_byte   (tx_byte),
    .tx_load   (tx_load)
  );

  cmd_decoder #(.num_slots(num_slots)) cmd_decoder_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .msg_start      (msg_start),
    .tx_byte        (tx_byte),
    .tx_load        (tx_load),
    .slot_wr_en     (slot_wr_en),
    .slot_wr_addr   (slot_wr_addr),
    .slot_wr_active (slot_wr_active),
    .bp_enable      (bp_enable),
    .resume_req     (resume_req)
  );

  // breakpoint slots
  for (genvar i = 0; i < num_slots; i++) begin : g_slot
    breakpoint_slot slot_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (slot_wr_en[i]),
      .wr_addr   (slot_wr_addr),
      .wr_active (slot_wr_active),
      .bus_addr  (bus_addr),
      .hit       (slot_hit[i])
    );
  end

  stub_control #(.num_slots(num_slots)) stub_control_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .slot_hit   (slot_hit),
    .bus_addr   (bus_addr),
    .bus_fetch  (bus_fetch),
    .bp_enable  (bp_enable),
    .resume_req (resume_req),
    .halted     (halted),
    .hit_index  (hit_index)
  );

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock #(
  parameter int period = 20
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
  end

  always #(period / 2) clk = ~clk; // half period per toggle

endmodule

// ==== sim/xray_checker.sv ====
module xray_checker (
  input  logic       clk,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       miso,
  input  logic       halted,
  input  logic [2:0] hit_index,
  input  logic       check,       // one cycle, compare now
  input  int         test_num,
  input  logic       exp_halted,
  input  logic [2:0] exp_hit,
  input  logic [7:0] exp_reply,
  input  logic       check_reply, // only when the test sent a message
  input  logic       done,
  output int         fail_count
);

  logic [7:0] reply_sr; // last byte seen on miso
  int         test_errs;
  int         pass_count;
  logic       reported;

  initial begin
    fail_count = 0;
    pass_count = 0;
    reported   = 1'b0;
    reply_sr   = '0;
  end

  // mode 0 capture on rising sck; cs_n falling with sck low starts a new message
  always @(posedge sck or negedge cs_n) begin
    if (!sck) reply_sr <= '0;
    else if (!cs_n) reply_sr <= {reply_sr[6:0], miso}; // msb first
  end

  task automatic compare_field(input string name, input logic [7:0] exp_v,
                               input logic [7:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERR time=%0t signal=%s expected=%02h actual=%02h", $time, name, exp_v, act_v);
      test_errs++;
    end
  endtask

  always @(posedge clk) begin
    if (check) begin
      test_errs = 0;
      compare_field("halted", {7'd0, exp_halted}, {7'd0, halted});
      compare_field("hit_index", {5'd0, exp_hit}, {5'd0, hit_index});
      if (check_reply) compare_field("miso_reply", exp_reply, reply_sr);
      if (test_errs == 0) begin
        pass_count++;
        $display("test %0d ok", test_num);
      end else begin
        fail_count++;
        $display("test %0d: %0d mismatches", test_num, test_errs);
      end
    end
    if (done && !reported) begin
      reported = 1'b1;
      $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
               fail_count);
    end
  end

endmodule

// ==== sim/xray_tb.sv ====
module xray_tb;

  localparam int num_tests = 21;
  localparam int cycle_limit = num_tests * 600 + 100; // worst test is well under 600 cycles

  // command bytes of the debug link
  localparam logic [7:0] op_cookie  = 8'h00;
  localparam logic [7:0] op_set_bp  = 8'h06;
  localparam logic [7:0] op_clr_bp  = 8'h07;
  localparam logic [7:0] op_enable  = 8'h0b;
  localparam logic [7:0] op_disable = 8'h0c;
  localparam logic [7:0] op_resume  = 8'h0d;
  localparam logic [7:0] op_version = 8'h0f;
  localparam logic [7:0] op_unknown = 8'h09;

  logic        clk;
  logic        rst_n;
  logic        sck;
  logic        mosi;
  logic        cs_n;
  logic        miso;
  logic [15:0] bus_addr;
  logic        bus_fetch;
  logic        halted;
  logic [2:0]  hit_index;

  // checker side
  logic        check;
  int          test_num;
  logic        exp_halted;
  logic [2:0]  exp_hit;
  logic [7:0]  exp_reply;
  logic        check_reply;
  logic        done;
  int          fail_count;

  // test table
  int          tbl_len   [num_tests];
  logic [7:0]  tbl_bytes [num_tests][4];
  logic        tbl_fetch [num_tests];
  logic [15:0] tbl_addr  [num_tests];
  logic        tbl_halt  [num_tests];
  logic [2:0]  tbl_hit   [num_tests];
  logic [7:0]  tbl_reply [num_tests];
  int          n_added;
  int          cycles;
  logic [31:0] rng;
  logic [15:0] a0;
  logic [15:0] a1;

  tb_clock #(.period(20)) clock_inst (.clk(clk));

  xray_top xray_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .miso      (miso),
    .bus_addr  (bus_addr),
    .bus_fetch (bus_fetch),
    .halted    (halted),
    .hit_index (hit_index)
  );

  xray_checker checker_inst (
    .clk(clk), .sck(sck), .cs_n(cs_n), .miso(miso), .halted(halted), .hit_index(hit_index),
    .check(check), .test_num(test_num), .exp_halted(exp_halted), .exp_hit(exp_hit),
    .exp_reply(exp_reply), .check_reply(check_reply), .done(done), .fail_count(fail_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_test(input int len, input logic [7:0] b0, input logic [7:0] b1,
                          input logic [7:0] b2, input logic [7:0] b3, input logic fetch,
                          input logic [15:0] addr, input logic halt, input logic [2:0] hit,
                          input logic [7:0] reply);
    tbl_len[n_added]      = len;
    tbl_bytes[n_added][0] = b0;
    tbl_bytes[n_added][1] = b1;
    tbl_bytes[n_added][2] = b2;
    tbl_bytes[n_added][3] = b3;
    tbl_fetch[n_added]    = fetch;
    tbl_addr[n_added]     = addr;
    tbl_halt[n_added]     = halt;
    tbl_hit[n_added]      = hit;
    tbl_reply[n_added]    = reply;
    n_added++;
  endtask

  // mode 0, msb first, half period of 4 clk
  task automatic spi_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      mosi = b[i];
      repeat (4) @(negedge clk);
      sck = 1'b1; // target samples here
      repeat (4) @(negedge clk);
      sck = 1'b0;
    end
  endtask

  // one framed message, shorter lists are aborted commands
  task automatic spi_message(input int t);
    cs_n = 1'b0;
    repeat (4) @(negedge clk);
    for (int k = 0; k < tbl_len[t]; k++) spi_byte(tbl_bytes[t][k]);
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    repeat (8) @(negedge clk); // command settles
  endtask

  task automatic cpu_fetch(input logic [15:0] addr);
    bus_addr  = addr;
    bus_fetch = 1'b1;
    @(negedge clk);
    bus_fetch = 1'b0; // single cycle strobe
  endtask

  // run limit
  initial cycles = 0;
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) begin
      $display("timeout: no end of tests after %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    sck = 1'b0;
    mosi = 1'b0;
    cs_n = 1'b1;
    bus_addr = '0;
    bus_fetch = 1'b0;
    check = 1'b0;
    test_num = 0;
    exp_halted = 1'b0;
    exp_hit = '0;
    exp_reply = '0;
    check_reply = 1'b0;
    done = 1'b0;
    n_added = 0;

    rng = xorshift32(32'd91997);
    a0  = rng[15:0];
    rng = xorshift32(rng);
    a1  = rng[15:0];
    if (a1 == a0) a1 = ~a0; // need two distinct addresses

    // bytes, fetch, fetch addr, halted, hit_index, reply
    add_test(2, op_cookie, 8'h00, 8'h00, 8'h00, 1'b0, 16'h0, 1'b0, 3'd0, 8'haf);
    add_test(2, op_version, 8'h00, 8'h00, 8'h00, 1'b0, 16'h0, 1'b0, 3'd0, {3'd0, 5'd3});
    add_test(4, op_set_bp, 8'd5, a0[7:0], a0[15:8], 1'b0, 16'h0, 1'b0, 3'd0, 8'h00);
    add_test(1, op_enable, 8'h00, 8'h00, 8'h00, 1'b1, a0 ^ 16'h1, 1'b0, 3'd0, 8'h00);
    add_test(0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1, a0, 1'b1, 3'd5, 8'h00);
    add_test(1, op_resume, 8'h00, 8'h00, 8'h00, 1'b1, a1, 1'b1, 3'd5, 8'h00); // not stop addr
    add_test(0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1, a0, 1'b0, 3'd5, 8'h00);
    add_test(0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1, a0, 1'b1, 3'd5, 8'h00);     // halts again
    add_test(1, op_resume, 8'h00, 8'h00, 8'h00, 1'b1, a0, 1'b0, 3'd5, 8'h00);
    add_test(1, op_disable, 8'h00, 8'h00, 8'h00, 1'b1, a0, 1'b0, 3'd5, 8'h00);
    add_test(1, op_enable, 8'h00, 8'h00, 8'h00, 1'b0, 16'h0, 1'b0, 3'd5, 8'h00);
    add_test(2, op_clr_bp, 8'd5, 8'h00, 8'h00, 1'b1, a0, 1'b0, 3'd5, 8'h00);
    add_test(4, op_set_bp, 8'd6, a1[7:0], a1[15:8], 1'b0, 16'h0, 1'b0, 3'd5, 8'h00);
    add_test(4, op_set_bp, 8'd2, a1[7:0], a1[15:8], 1'b1, a1, 1'b1, 3'd2, 8'h00); // lower wins
    add_test(1, op_resume, 8'h00, 8'h00, 8'h00, 1'b1, a1, 1'b0, 3'd2, 8'h00);
    add_test(1, op_unknown, 8'h00, 8'h00, 8'h00, 1'b1, a1, 1'b1, 3'd2, 8'h00);
    add_test(1, op_resume, 8'h00, 8'h00, 8'h00, 1'b1, a1, 1'b0, 3'd2, 8'h00);
    add_test(1, op_clr_bp, 8'h00, 8'h00, 8'h00, 1'b1, a1, 1'b1, 3'd2, 8'h00); // clear cut short
    add_test(1, op_resume, 8'h00, 8'h00, 8'h00, 1'b1, a1, 1'b0, 3'd2, 8'h00);
    add_test(3, op_set_bp, 8'd1, a1[7:0], 8'h00, 1'b1, a1, 1'b1, 3'd2, 8'h00); // set cut short
    add_test(1, op_resume, 8'h00, 8'h00, 8'h00, 1'b1, a1, 1'b0, 3'd2, 8'h00);

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    for (int t = 0; t < num_tests; t++) begin
      if (tbl_len[t] > 0) spi_message(t);
      if (tbl_fetch[t]) cpu_fetch(tbl_addr[t]);
      repeat (2) @(negedge clk); // halted follows one cycle after the fetch
      test_num    = t;
      exp_halted  = tbl_halt[t];
      exp_hit     = tbl_hit[t];
      exp_reply   = tbl_reply[t];
      check_reply = (tbl_len[t] > 0);
      check       = 1'b1;
      @(negedge clk);
      check = 1'b0;
    end

    done = 1'b1;
    @(negedge clk); // counts line first
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/xray_pkg.sv
verilog/spi_target.sv
verilog/cmd_decoder.sv
verilog/breakpoint_slot.sv
verilog/stub_control.sv
verilog/xray_top.sv
sim/tb_clock.sv
sim/xray_checker.sv
sim/xray_tb.sv

// ==== Bender.yml ====
package:
  name: xray_debug

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/xray_pkg.sv
      - verilog/spi_target.sv
      - verilog/cmd_decoder.sv
      - verilog/breakpoint_slot.sv
      - verilog/stub_control.sv
      - verilog/xray_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/xray_checker.sv
      - sim/xray_tb.sv
